// ==== rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// ----------------------------------------------------------------------
// Core dimensions
// ----------------------------------------------------------------------

// Data path and address width
`define XLEN 32

// Register index width and register count
`define REG_ADDR_W 5
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------

    // Major opcodes kept by this core, anything else retires as a NOP
    typedef enum logic [6:0]
    {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // ALU operations, PASS_B carries the LUI immediate through
    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // ------------------------------------------------------------------
    // Pipeline records
    // ------------------------------------------------------------------

    // Decoder output, held in the execute register
    typedef struct packed
    {
        alu_op_e                alu_op;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rf_write;
        logic                   use_imm;
        logic [`XLEN-1:0]       imm;
    } decoded_t;

    // Result moving from execute towards write-back
    typedef struct packed
    {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
    } stage_t;

    // Outside view of a register write
    typedef struct packed
    {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
    } retire_t;

endpackage

`default_nettype wire

// ==== rv_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_decoder
(
    input  wire logic [`XLEN-1:0] instr,
    output rv_core_pkg::decoded_t dec
);
    // funct7 patterns of the base and alternate (SUB, SRA) encodings
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // ------------------------------------------------------------------
    // Instruction fields
    // ------------------------------------------------------------------
    rv_core_pkg::opcode_e opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`XLEN-1:0]     imm_i;
    logic [`XLEN-1:0]     imm_u;
    logic                 alt;

    assign opcode = rv_core_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // I-type sign extended, U-type upper twenty bits
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // Alternate op only for SRAI in the immediate group, OP uses it for SUB too
    assign alt = funct7[5] && (opcode == rv_core_pkg::OPC_OP || funct3 == 3'b101);

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    always_comb
    begin
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.rd       = instr[11:7];
        dec.rf_write = 1'b0;
        dec.use_imm  = 1'b0;
        dec.imm      = imm_i;

        // funct3 map shared by both integer groups
        case (funct3)
            3'b000:  dec.alu_op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  dec.alu_op = rv_core_pkg::ALU_SLL;
            3'b010:  dec.alu_op = rv_core_pkg::ALU_SLT;
            3'b011:  dec.alu_op = rv_core_pkg::ALU_SLTU;
            3'b100:  dec.alu_op = rv_core_pkg::ALU_XOR;
            3'b101:  dec.alu_op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  dec.alu_op = rv_core_pkg::ALU_OR;
            default: dec.alu_op = rv_core_pkg::ALU_AND;
        endcase

        case (opcode)
            rv_core_pkg::OPC_OP_IMM:
            begin
                dec.use_imm = 1'b1;
                // Shift immediates must carry a legal funct7
                if (funct3 == 3'b001)
                    dec.rf_write = (funct7 == F7_BASE);
                else if (funct3 == 3'b101)
                    dec.rf_write = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                else
                    dec.rf_write = 1'b1;
            end
            rv_core_pkg::OPC_OP:
            begin
                // Only ADD and SRL have an alternate form
                dec.rf_write = (funct7 == F7_BASE) ||
                               (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rv_core_pkg::OPC_LUI:
            begin
                dec.alu_op   = rv_core_pkg::ALU_PASS_B;
                dec.use_imm  = 1'b1;
                dec.imm      = imm_u;
                dec.rf_write = 1'b1;
            end
            // Unknown opcode stays a NOP
            default: dec.rf_write = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_register_file
(
    input  wire logic                   CLK,
    input  wire logic                   reset,
    input  wire logic [`REG_ADDR_W-1:0] rs1,
    input  wire logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]            rd1,
    output logic [`XLEN-1:0]            rd2,
    input  wire rv_core_pkg::stage_t    wr
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    // ------------------------------------------------------------------
    // Write port, takes effect at the next edge
    // ------------------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wr.valid && wr.rd != '0)
        begin
            regs[wr.rd] <= wr.result;
        end
    end

    // Read ports, old value on a same-cycle write
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    // Decode never lets an x0 write reach write-back
    a_no_x0_write: assert property (@(posedge CLK) disable iff (reset)
        wr.valid |-> wr.rd != '0);

endmodule

`default_nettype wire

// ==== rv_forward_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_forward_unit
(
    input  wire logic [`REG_ADDR_W-1:0] src,
    input  wire logic [`XLEN-1:0]       rf_data,
    input  wire rv_core_pkg::stage_t    ex,
    input  wire rv_core_pkg::stage_t    mem,
    input  wire rv_core_pkg::stage_t    wb,
    output logic [`XLEN-1:0]            operand
);
    // Source of the operand
    localparam logic [1:0] SEL_RF  = 2'd0;
    localparam logic [1:0] SEL_EX  = 2'd1;
    localparam logic [1:0] SEL_MEM = 2'd2;
    localparam logic [1:0] SEL_WB  = 2'd3;

    logic [1:0] sel;

    // ------------------------------------------------------------------
    // Priority with the youngest stage first
    // ------------------------------------------------------------------
    always_comb
    begin
        if (src == '0)
            sel = SEL_RF;
        else if (ex.valid && ex.rd == src)
            sel = SEL_EX;
        else if (mem.valid && mem.rd == src)
            sel = SEL_MEM;
        else if (wb.valid && wb.rd == src)
            sel = SEL_WB;
        else
            sel = SEL_RF;
    end

    always_comb
    begin
        case (sel)
            SEL_EX:  operand = ex.result;
            SEL_MEM: operand = mem.result;
            SEL_WB:  operand = wb.result;
            default: operand = rf_data;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_alu
(
    input  wire rv_core_pkg::alu_op_e op,
    input  wire logic [`XLEN-1:0]     a,
    input  wire logic [`XLEN-1:0]     b,
    output logic [`XLEN-1:0]          result
);
    // Shift amount from the low bits of operand B
    logic [4:0] shamt;

    assign shamt = b[4:0];

    // ------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------
    always_comb
    begin
        case (op)
            rv_core_pkg::ALU_ADD:    result = a + b;
            rv_core_pkg::ALU_SUB:    result = a - b;
            rv_core_pkg::ALU_SLL:    result = a << shamt;
            // Compares give a single bit, zero extended
            rv_core_pkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            rv_core_pkg::ALU_SLTU:   result = {31'b0, a < b};
            rv_core_pkg::ALU_XOR:    result = a ^ b;
            rv_core_pkg::ALU_SRL:    result = a >> shamt;
            // Arithmetic shift keeps the sign
            rv_core_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            rv_core_pkg::ALU_OR:     result = a | b;
            rv_core_pkg::ALU_AND:    result = a & b;
            rv_core_pkg::ALU_PASS_B: result = b;
            default:                 result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core
(
    input  wire logic              CLK,
    input  wire logic              reset,
    output logic [`XLEN-1:0]       fetch_addr,
    input  wire logic [`XLEN-1:0]  fetch_instr,
    output rv_core_pkg::retire_t   retire
);
    // ------------------------------------------------------------------
    // Fetch, plain program counter
    // ------------------------------------------------------------------
    logic [`XLEN-1:0] pc;

    always_ff @(posedge CLK)
    begin
        if (reset)
            pc <= `RESET_PC;
        else
            pc <= pc + 32'd4;
    end

    assign fetch_addr = pc;

    // ------------------------------------------------------------------
    // Decode stage
    // ------------------------------------------------------------------
    logic [`XLEN-1:0]      id_instr;
    logic                  id_valid;
    rv_core_pkg::decoded_t id_dec;
    logic [`XLEN-1:0]      id_rf1;
    logic [`XLEN-1:0]      id_rf2;
    logic [`XLEN-1:0]      id_op1;
    logic [`XLEN-1:0]      id_op2;

    // Instruction word has no reset, only its valid bit
    always_ff @(posedge CLK)
    begin
        id_instr <= fetch_instr;
        id_valid <= !reset;
    end

    rv_decoder u_decoder
    (
        .instr (id_instr),
        .dec   (id_dec)
    );

    // Write-back result feeds the register file
    rv_core_pkg::stage_t ex_stage;
    rv_core_pkg::stage_t mem_stage;
    rv_core_pkg::stage_t wb_stage;

    rv_register_file u_register_file
    (
        .CLK   (CLK),
        .reset (reset),
        .rs1   (id_dec.rs1),
        .rs2   (id_dec.rs2),
        .rd1   (id_rf1),
        .rd2   (id_rf2),
        .wr    (wb_stage)
    );

    // One forward unit per source register
    rv_forward_unit u_forward_rs1
    (
        .src     (id_dec.rs1),
        .rf_data (id_rf1),
        .ex      (ex_stage),
        .mem     (mem_stage),
        .wb      (wb_stage),
        .operand (id_op1)
    );

    rv_forward_unit u_forward_rs2
    (
        .src     (id_dec.rs2),
        .rf_data (id_rf2),
        .ex      (ex_stage),
        .mem     (mem_stage),
        .wb      (wb_stage),
        .operand (id_op2)
    );

    // ------------------------------------------------------------------
    // Execute stage
    // ------------------------------------------------------------------
    rv_core_pkg::decoded_t ex_dec;
    logic                  ex_valid;
    logic [`XLEN-1:0]      ex_op1;
    logic [`XLEN-1:0]      ex_op2;
    logic [`XLEN-1:0]      ex_b;
    logic [`XLEN-1:0]      ex_result;

    always_ff @(posedge CLK)
    begin
        ex_dec   <= id_dec;
        ex_op1   <= id_op1;
        ex_op2   <= id_op2;
        ex_valid <= reset ? 1'b0 : id_valid;
    end

    // Immediate or rs2 as operand B
    assign ex_b = ex_dec.use_imm ? ex_dec.imm : ex_op2;

    rv_alu u_alu
    (
        .op     (ex_dec.alu_op),
        .a      (ex_op1),
        .b      (ex_b),
        .result (ex_result)
    );

    // Valid only for real writes to a nonzero register
    assign ex_stage.valid  = ex_valid && ex_dec.rf_write && (ex_dec.rd != '0);
    assign ex_stage.rd     = ex_dec.rd;
    assign ex_stage.result = ex_result;

    // ------------------------------------------------------------------
    // Memory and write-back stages
    // ------------------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        mem_stage <= ex_stage;
        wb_stage  <= mem_stage;
        // Reset drops the in-flight records, payload is left alone
        if (reset)
        begin
            mem_stage.valid <= 1'b0;
            wb_stage.valid  <= 1'b0;
        end
    end

    assign retire.valid  = wb_stage.valid;
    assign retire.rd     = wb_stage.rd;
    assign retire.result = wb_stage.result;

    // A retire always names a real destination register
    a_retire_rd: assert property (@(posedge CLK) disable iff (reset)
        retire.valid |-> retire.rd != '0);

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core;

    localparam int CLK_HALF = 10;
    localparam int MAX_PROG = 128;
    // ADDI x0, x0, 0
    localparam logic [`XLEN-1:0] NOP_WORD = 32'h0000_0013;

    // Table entry with an instruction word and the retire it should produce
    typedef struct packed
    {
        logic [`XLEN-1:0]     instr;
        rv_core_pkg::retire_t exp;
    } entry_t;

    // Expected retire with the cycle it is due in
    typedef struct packed
    {
        logic [31:0]          cycle;
        logic [31:0]          index;
        rv_core_pkg::retire_t rec;
    } pending_t;

    logic                 CLK;
    logic                 reset;
    logic [`XLEN-1:0]     fetch_addr;
    logic [`XLEN-1:0]     fetch_instr;
    rv_core_pkg::retire_t retire;

    entry_t           prog [MAX_PROG];
    int               prog_len;
    logic [`XLEN-1:0] model_regs [`REG_COUNT];
    logic [31:0]      lfsr;
    pending_t         expect_q [$];
    pending_t         head_rec;
    int               edge_count;
    int               value_errors;
    int               order_errors;
    logic             checking;
    logic             built = 1'b0;

    rv_core u_rv_core
    (
        .CLK         (CLK),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .retire      (retire)
    );

    // Instruction memory with a NOP past the end of the table
    assign fetch_instr = (fetch_addr[`XLEN-1:2] < prog_len) ?
                         prog[fetch_addr[`XLEN-1:2]].instr : NOP_WORD;

    initial
    begin
        CLK = 1'b0;
        forever #CLK_HALF CLK = ~CLK;
    end

    // ----------------------------------------------------------------------
    // Encoders and reference model
    // ----------------------------------------------------------------------
    function automatic logic [2:0] funct3_of(input rv_core_pkg::alu_op_e op);
        case (op)
            rv_core_pkg::ALU_SLL:  return 3'b001;
            rv_core_pkg::ALU_SLT:  return 3'b010;
            rv_core_pkg::ALU_SLTU: return 3'b011;
            rv_core_pkg::ALU_XOR:  return 3'b100;
            rv_core_pkg::ALU_SRL:  return 3'b101;
            rv_core_pkg::ALU_SRA:  return 3'b101;
            rv_core_pkg::ALU_OR:   return 3'b110;
            rv_core_pkg::ALU_AND:  return 3'b111;
            default:               return 3'b000;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] encode_r(input rv_core_pkg::alu_op_e op,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] f7;
        // SUB and SRA use the alternate funct7
        f7 = (op == rv_core_pkg::ALU_SUB || op == rv_core_pkg::ALU_SRA) ? 7'b0100000 : 7'b0;
        return {f7, rs2, rs1, funct3_of(op), rd, 7'b0110011};
    endfunction

    function automatic logic [`XLEN-1:0] reference_alu(input rv_core_pkg::alu_op_e op,
        input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        case (op)
            rv_core_pkg::ALU_ADD:  return a + b;
            rv_core_pkg::ALU_SUB:  return a - b;
            rv_core_pkg::ALU_SLL:  return a << b[4:0];
            // Different signs decide by the sign of a, equal signs compare as unsigned
            rv_core_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            rv_core_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            rv_core_pkg::ALU_XOR:  return a ^ b;
            rv_core_pkg::ALU_SRL:  return a >> b[4:0];
            // Logical shift with the vacated upper bits filled from the sign
            rv_core_pkg::ALU_SRA:  return (a >> b[4:0]) |
                                          (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
            rv_core_pkg::ALU_OR:   return a | b;
            rv_core_pkg::ALU_AND:  return a & b;
            default:               return b;
        endcase
    endfunction

    // Galois LFSR on x^32 + x^22 + x^2 + x + 1 with one step per bit
    function automatic logic take_bit();
        logic lsb;
        lsb = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb)
            lfsr = lfsr ^ 32'h8020_0003;
        return lsb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], take_bit()};
        return v;
    endfunction

    // Adds one table entry and updates the model registers
    task automatic add_entry(input logic [`XLEN-1:0] instr, input logic writes,
        input logic [4:0] rd, input logic [`XLEN-1:0] value);
        prog[prog_len].instr      = instr;
        prog[prog_len].exp.valid  = writes && (rd != 5'd0);
        prog[prog_len].exp.rd     = rd;
        prog[prog_len].exp.result = value;
        if (writes && rd != 5'd0)
            model_regs[rd] = value;
        prog_len++;
    endtask

    task automatic op_r(input rv_core_pkg::alu_op_e op, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [4:0] rs2);
        add_entry(encode_r(op, rd, rs1, rs2), 1'b1, rd,
                  reference_alu(op, model_regs[rs1], model_regs[rs2]));
    endtask

    task automatic op_i(input rv_core_pkg::alu_op_e op, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [11:0] imm);
        logic [11:0] field;
        field = imm;
        // Shift immediates carry funct7 in the upper bits
        if (op == rv_core_pkg::ALU_SLL || op == rv_core_pkg::ALU_SRL)
            field = {7'b0, imm[4:0]};
        else if (op == rv_core_pkg::ALU_SRA)
            field = {7'b0100000, imm[4:0]};
        add_entry({field, rs1, funct3_of(op), rd, 7'b0010011}, 1'b1, rd,
                  reference_alu(op, model_regs[rs1], {{20{field[11]}}, field}));
    endtask

    task automatic op_lui(input logic [4:0] rd, input logic [19:0] imm);
        add_entry({imm, rd, 7'b0110111}, 1'b1, rd, {imm, 12'b0});
    endtask

    // ----------------------------------------------------------------------
    // Program table
    // ----------------------------------------------------------------------
    task automatic build_program();
        logic [19:0] upper;
        // Full 32-bit constants from LUI then ADDI or ORI
        op_lui(5'd1, 20'h12345);
        op_i(rv_core_pkg::ALU_ADD, 5'd1, 5'd1, 12'h678);
        op_lui(5'd2, 20'hDEADC);
        op_i(rv_core_pkg::ALU_ADD, 5'd2, 5'd2, 12'hEEF);
        op_i(rv_core_pkg::ALU_OR, 5'd3, 5'd0, 12'h5A5);
        op_lui(5'd4, 20'h80000);
        op_i(rv_core_pkg::ALU_OR, 5'd4, 5'd4, 12'h7FF);
        // Dependent chain where each reads the previous rd
        op_r(rv_core_pkg::ALU_ADD, 5'd5, 5'd1, 5'd2);
        op_r(rv_core_pkg::ALU_SUB, 5'd6, 5'd5, 5'd1);
        op_r(rv_core_pkg::ALU_XOR, 5'd7, 5'd6, 5'd5);
        op_r(rv_core_pkg::ALU_ADD, 5'd8, 5'd7, 5'd6);
        // x5 is four back here and comes from the register file
        op_r(rv_core_pkg::ALU_SUB, 5'd9, 5'd8, 5'd5);
        // x7 is three back here and comes from write-back
        op_r(rv_core_pkg::ALU_XOR, 5'd10, 5'd9, 5'd7);
        // Compares and shifts on LFSR operands
        // Odd rounds force a negative x11
        for (int k = 0; k < 6; k++)
        begin
            upper = 20'(random_bits(20));
            if (k % 2 == 1)
                upper[19] = 1'b1;
            op_lui(5'd11, upper);
            op_i(rv_core_pkg::ALU_ADD, 5'd11, 5'd11, 12'(random_bits(12)));
            op_lui(5'd12, 20'(random_bits(20)));
            op_i(rv_core_pkg::ALU_OR, 5'd12, 5'd12, 12'(random_bits(12)));
            op_r(rv_core_pkg::ALU_SLT, 5'd13, 5'd11, 5'd12);
            op_r(rv_core_pkg::ALU_SLTU, 5'd14, 5'd11, 5'd12);
            op_i(rv_core_pkg::ALU_SLT, 5'd15, 5'd11, 12'(random_bits(12)));
            op_i(rv_core_pkg::ALU_SLTU, 5'd16, 5'd11, 12'(random_bits(12)));
            op_r(rv_core_pkg::ALU_SLL, 5'd17, 5'd11, 5'd12);
            op_r(rv_core_pkg::ALU_SRL, 5'd18, 5'd11, 5'd12);
            op_r(rv_core_pkg::ALU_SRA, 5'd19, 5'd11, 5'd12);
            op_i(rv_core_pkg::ALU_SLL, 5'd20, 5'd11, 12'(random_bits(5)));
            op_i(rv_core_pkg::ALU_SRL, 5'd21, 5'd11, 12'(random_bits(5)));
            op_i(rv_core_pkg::ALU_SRA, 5'd22, 5'd11, 12'(random_bits(5)));
        end
        // Writes to x0 are dropped and x0 still reads zero
        op_i(rv_core_pkg::ALU_ADD, 5'd0, 5'd1, 12'h005);
        op_r(rv_core_pkg::ALU_ADD, 5'd0, 5'd1, 5'd2);
        op_r(rv_core_pkg::ALU_ADD, 5'd23, 5'd0, 5'd0);
        op_i(rv_core_pkg::ALU_OR, 5'd24, 5'd0, 12'h007);
        // LW x25 and a MUL encoding both act as NOPs
        op_i(rv_core_pkg::ALU_ADD, 5'd25, 5'd3, 12'h001);
        add_entry({12'h000, 5'd1, 3'b010, 5'd25, 7'b0000011}, 1'b0, 5'd0, '0);
        op_i(rv_core_pkg::ALU_ADD, 5'd26, 5'd25, 12'h001);
        add_entry({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd27, 7'b0110011}, 1'b0, 5'd0, '0);
        op_r(rv_core_pkg::ALU_OR, 5'd27, 5'd27, 5'd26);
    endtask

    // ----------------------------------------------------------------------
    // Retire checker sampling on the falling edge
    // ----------------------------------------------------------------------
    always @(posedge CLK)
    begin
        if (reset)
            edge_count <= 0;
        else
            edge_count <= edge_count + 1;
    end

    always @(negedge CLK)
    begin
        if (checking)
        begin
            if (retire.valid)
            begin
                if (expect_q.size() == 0 || expect_q[0].cycle != edge_count)
                begin
                    $display("Unexpected retire to x%0d in cycle %0d", retire.rd, edge_count);
                    order_errors++;
                end
                else
                begin
                    head_rec = expect_q.pop_front();
                    if (retire.rd != head_rec.rec.rd)
                    begin
                        $display("** Error: retire.rd expected 0x%h got 0x%h (entry %0d)",
                                 head_rec.rec.rd, retire.rd, head_rec.index);
                        value_errors++;
                    end
                    if (retire.result != head_rec.rec.result)
                    begin
                        $display("** Error: retire.result expected 0x%h got 0x%h (entry %0d)",
                                 head_rec.rec.result, retire.result, head_rec.index);
                        value_errors++;
                    end
                end
            end
            else if (expect_q.size() != 0 && expect_q[0].cycle == edge_count)
            begin
                $display("Missing retire of entry %0d in cycle %0d", expect_q[0].index,
                         edge_count);
                order_errors++;
                void'(expect_q.pop_front());
            end
        end
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial
    begin
        pending_t rec;
        reset        = 1'b1;
        prog_len     = 0;
        lfsr         = 32'd12;
        value_errors = 0;
        order_errors = 0;
        checking     = 1'b0;
        for (int r = 0; r < `REG_COUNT; r++)
            model_regs[r] = '0;
        build_program();
        built = 1'b1;

        repeat (5) @(posedge CLK);
        #1;
        reset    = 1'b0;
        checking = 1'b1;

        // Entry i is fetched at edge i+1 and retires after edge i+4
        for (int i = 0; i < prog_len; i++)
        begin
            // Fetch address starts at the reset address and steps one word per edge
            if (fetch_addr != `RESET_PC + 32'(4 * i))
            begin
                $display("** Error: fetch_addr expected 0x%h got 0x%h",
                         `RESET_PC + 32'(4 * i), fetch_addr);
                value_errors++;
            end
            @(posedge CLK);
            #1;
            if (prog[i].exp.valid)
            begin
                rec.cycle = 32'(i + 4);
                rec.index = 32'(i);
                rec.rec   = prog[i].exp;
                expect_q.push_back(rec);
            end
        end

        // Drain the pipeline
        repeat (8) @(posedge CLK);
        #1;
        $display("Errors: %0d wrong values, %0d missing or extra retires",
                 value_errors, order_errors);
        if (value_errors + order_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog sized from the table length
    initial
    begin
        wait (built);
        #((prog_len + 20) * 2 * CLK_HALF);
        $display("Watchdog expired before the run finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
rv_core_pkg.sv
rv_decoder.sv
rv_register_file.sv
rv_forward_unit.sv
rv_alu.sv
rv_core.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - files:
      - rv_core_pkg.sv
      - rv_decoder.sv
      - rv_register_file.sv
      - rv_forward_unit.sv
      - rv_alu.sv
      - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv
